// File: include/soc_params.svh
// ****************************************
// Bus widths, address map sizes, device
// IDs and reset counter width of the SoC
// ****************************************

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// PI1 bus widths
`define ARCHBITSZ 32
`define ADDRBITSZ 30
`define SELBITSZ 4

// Number of slots in the address map
`define SLOTCOUNT 8

// Slot sizes in words, in map order
`define MAPSZ_RAM 'h2000000
`define MAPSZ_RAMCTRL 'h1000
`define MAPSZ_BOOTLDR 'h1000
`define MAPSZ_SDCARD 'h400
`define MAPSZ_DEVTBL 'h400
`define MAPSZ_INTCTRL 'h400
`define MAPSZ_SERIAL 'h400
`define MAPSZ_INVALID 'h400

// Device IDs reported by the device table
`define DEVID_RAM 1
`define DEVID_RAMCTRL 0
`define DEVID_BOOTLDR 0
`define DEVID_SDCARD 4
`define DEVID_DEVTBL 7
`define DEVID_INTCTRL 3
`define DEVID_SERIAL 5
`define DEVID_INVALID 0

// SD card (slot 3) and serial (slot 6) raise interrupts
`define USEINTR_MASK 8'h48

`define SOCID 5
`define DEVTBL_SOCID_OFS 16
`define DEVTBL_RSTCTL_OFS 17

// 63-cycle reset stretch in simulation
`define RST_CNTR_BITSZ 6

`endif

// File: rtl/soc_pkg.sv
// ****************************************
// PI1 op and map slot enums, PI1 request
// and response structs, external request
// ****************************************

`include "soc_params.svh"

package soc_pkg;

	// PI1 operation codes
	typedef enum logic [1:0] {
		PI1_NOOP   = 2'b00,
		PI1_WROP   = 2'b01,
		PI1_RDOP   = 2'b10,
		// Write that hands back the previous word
		PI1_RDWROP = 2'b11
	} pi1_op_e;

	// Address map slots, in map order
	typedef enum logic [2:0] {
		SLOT_RAM     = 3'd0,
		SLOT_RAMCTRL = 3'd1,
		SLOT_BOOTLDR = 3'd2,
		SLOT_SDCARD  = 3'd3,
		SLOT_DEVTBL  = 3'd4,
		SLOT_INTCTRL = 3'd5,
		SLOT_SERIAL  = 3'd6,
		SLOT_INVALID = 3'd7
	} slot_e;

	// Master side of a PI1 link
	typedef struct packed {
		pi1_op_e                op;
		logic [`ADDRBITSZ-1:0]  addr;
		logic [`ARCHBITSZ-1:0]  data;
		logic [`SELBITSZ-1:0]   sel;
	} pi1_req_t;

	// Slave side of a PI1 link
	typedef struct packed {
		logic [`ARCHBITSZ-1:0]  data;
		logic                   rdy;
	} pi1_rsp_t;

	// Request to the external port, addr is the offset in the slot
	typedef struct packed {
		pi1_req_t  req;
		slot_e     slot;
	} ext_req_t;

endpackage

// File: rtl/reset_sequencer.sv
// ****************************************
// System reset sequencer: reset counter,
// software reset decode, power-off latch
// ****************************************

`timescale 1ns/10ps

`include "soc_params.svh"

module reset_sequencer (
	input  logic  clk48mhz_i,
	input  logic  rst_p,
	input  logic  cpu_rst_req_i,
	input  logic  sw_rst0_i,
	input  logic  sw_rst1_i,
	output logic  sys_rst_o
);

	// Software reset code as {rst1, rst0}
	typedef enum logic [1:0] {
		SW_RST_NONE   = 2'b00,
		SW_RST_PWROFF = 2'b01,
		SW_RST_WARM   = 2'b10,
		SW_RST_COLD   = 2'b11
	} sw_rst_e;

	sw_rst_e                    sw_code;
	logic                       sw_warm;
	logic                       sw_pwroff;
	logic [`RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                       pwroff_latch;

	assign sw_code = sw_rst_e'({sw_rst1_i, sw_rst0_i});

	always_comb begin
		sw_warm   = 1'b0;
		sw_pwroff = 1'b0;
		unique case (sw_code)
			SW_RST_WARM:   sw_warm = 1'b1;
			SW_RST_PWROFF: sw_pwroff = 1'b1;
			// Cold reset needs a global-reset primitive, so it has no effect
			default: ;
		endcase
	end

	// Reload while any reset source is active, then count down
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || cpu_rst_req_i || sw_warm) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off holds the system until the button reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_latch <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_latch <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) || pwroff_latch;

	// Once powered off the system stays in reset until rst_p
	a_pwroff_holds : assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		pwroff_latch |=> (pwroff_latch && sys_rst_o));

endmodule

// File: rtl/pi1_addr_decoder.sv
// ****************************************
// PI1 address decoder: slot select, offset,
// request routing, response select and the
// invalid-device responder
// ****************************************

`timescale 1ns/10ps

`include "soc_params.svh"

module pi1_addr_decoder (
	input  logic               clk48mhz_i,
	input  logic               rst_p,
	input  soc_pkg::pi1_req_t  m_req_i,
	output soc_pkg::pi1_rsp_t  m_rsp_o,
	output soc_pkg::pi1_req_t  tbl_req_o,
	input  soc_pkg::pi1_rsp_t  tbl_rsp_i,
	output soc_pkg::ext_req_t  ext_req_o,
	input  soc_pkg::pi1_rsp_t  ext_rsp_i
);

	import soc_pkg::*;

	// Slot sizes in map order, bases are their running sum
	localparam logic [`ADDRBITSZ-1:0] SLOT_MAPSZ [`SLOTCOUNT] = '{
		`MAPSZ_RAM, `MAPSZ_RAMCTRL, `MAPSZ_BOOTLDR, `MAPSZ_SDCARD,
		`MAPSZ_DEVTBL, `MAPSZ_INTCTRL, `MAPSZ_SERIAL, `MAPSZ_INVALID
	};

	slot_e                  slot_sel;
	logic [`ADDRBITSZ-1:0]  slot_base;
	logic [`ADDRBITSZ-1:0]  ofs;

	// Anything not inside a slot, including past the map end, is invalid
	always_comb begin
		logic [`ADDRBITSZ-1:0] base;
		base      = '0;
		slot_sel  = SLOT_INVALID;
		slot_base = '0;
		for (int k = 0; k < `SLOTCOUNT; k++) begin
			if (m_req_i.addr >= base && m_req_i.addr < base + SLOT_MAPSZ[k]) begin
				slot_sel  = slot_e'(3'(k));
				slot_base = base;
			end
			base = base + SLOT_MAPSZ[k];
		end
	end

	assign ofs = m_req_i.addr - slot_base;

	// Op only reaches the chosen side, others see NOOP
	always_comb begin
		tbl_req_o          = m_req_i;
		tbl_req_o.addr     = ofs;
		tbl_req_o.op       = PI1_NOOP;
		ext_req_o.req      = m_req_i;
		ext_req_o.req.addr = ofs;
		ext_req_o.req.op   = PI1_NOOP;
		ext_req_o.slot     = slot_sel;
		m_rsp_o            = '0;
		unique case (slot_sel)
			SLOT_DEVTBL: begin
				tbl_req_o.op = m_req_i.op;
				m_rsp_o      = tbl_rsp_i;
			end
			// Zero data, answered in the same cycle
			SLOT_INVALID: m_rsp_o.rdy = 1'b1;
			default: begin
				ext_req_o.req.op = m_req_i.op;
				m_rsp_o          = ext_rsp_i;
			end
		endcase
	end

	a_ext_quiet : assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		(slot_sel inside {SLOT_DEVTBL, SLOT_INVALID}) |-> (ext_req_o.req.op == PI1_NOOP));

	// Device table answers only to a request it saw on the previous edge
	a_tbl_rdy_late : assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		(slot_sel == SLOT_DEVTBL && m_req_i.op != PI1_NOOP && m_rsp_o.rdy)
		|-> ($past(tbl_req_o.op) != PI1_NOOP));

endmodule

// File: rtl/devtbl.sv
// ****************************************
// Device table: per-slot ID and map size
// words, SoC ID and reset-control register
// ****************************************

`timescale 1ns/10ps

`include "soc_params.svh"

module devtbl (
	input  logic               clk48mhz_i,
	input  logic               rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	output soc_pkg::pi1_rsp_t  rsp_o,
	output logic               sw_rst0_o,
	output logic               sw_rst1_o
);

	import soc_pkg::*;

	localparam int IDXW = $clog2(`SLOTCOUNT);

	localparam logic [`ARCHBITSZ-1:0] DEV_ID [`SLOTCOUNT] = '{
		`DEVID_RAM, `DEVID_RAMCTRL, `DEVID_BOOTLDR, `DEVID_SDCARD,
		`DEVID_DEVTBL, `DEVID_INTCTRL, `DEVID_SERIAL, `DEVID_INVALID
	};
	localparam logic [`ADDRBITSZ-1:0] DEV_MAPSZ [`SLOTCOUNT] = '{
		`MAPSZ_RAM, `MAPSZ_RAMCTRL, `MAPSZ_BOOTLDR, `MAPSZ_SDCARD,
		`MAPSZ_DEVTBL, `MAPSZ_INTCTRL, `MAPSZ_SERIAL, `MAPSZ_INVALID
	};
	localparam logic [`SLOTCOUNT-1:0]  DEV_USEINTR = `USEINTR_MASK;
	localparam logic [`ADDRBITSZ-1:0]  SLOT_WORDS  = 2 * `SLOTCOUNT;
	localparam logic [`ADDRBITSZ-1:0]  SOCID_OFS   = `DEVTBL_SOCID_OFS;
	localparam logic [`ADDRBITSZ-1:0]  RSTCTL_OFS  = `DEVTBL_RSTCTL_OFS;
	localparam logic [`ARCHBITSZ-1:0]  SOCID_WORD  = `SOCID;

	logic [`ADDRBITSZ-1:0]  ofs;
	logic [IDXW-1:0]        idx;
	logic [`ARCHBITSZ-1:0]  rd_word;
	logic [`ARCHBITSZ-1:0]  rd_data_q;
	logic                   rdy_q;
	logic                   req_vld;
	logic                   wr_en;
	logic                   rst0_q;
	logic                   rst1_q;

	assign ofs = req_i.addr;
	// Two words per slot, ID first
	assign idx = ofs[IDXW:1];

	always_comb begin
		rd_word = '0;
		if (ofs < SLOT_WORDS) begin
			if (ofs[0]) begin
				rd_word[`ADDRBITSZ-1:0] = DEV_MAPSZ[idx];
				rd_word[`ARCHBITSZ-1]   = DEV_USEINTR[idx];
			end else begin
				rd_word = DEV_ID[idx];
			end
		end else if (ofs == SOCID_OFS) begin
			rd_word = SOCID_WORD;
		end else if (ofs == RSTCTL_OFS) begin
			rd_word[1:0] = {rst1_q, rst0_q};
		end
	end

	// Serve when no rdy is out, so a held request is served again later
	assign req_vld = (req_i.op != PI1_NOOP) && !rdy_q;
	assign wr_en   = req_vld && (req_i.op inside {PI1_WROP, PI1_RDWROP}) &&
		(ofs == RSTCTL_OFS) && req_i.sel[0];

	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			rdy_q  <= 1'b0;
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else begin
			rdy_q <= req_vld;
			if (wr_en) begin
				rst0_q <= req_i.data[0];
				rst1_q <= req_i.data[1];
			end
		end
	end

	// Old word is captured, so RDWROP returns the previous value
	always_ff @(posedge clk48mhz_i) begin
		if (req_vld) begin
			rd_data_q <= rd_word;
		end
	end

	assign rsp_o.data = rd_data_q;
	assign rsp_o.rdy  = rdy_q;
	assign sw_rst0_o  = rst0_q;
	assign sw_rst1_o  = rst1_q;

endmodule

// File: rtl/soc_ctrl_top.sv
// ****************************************
// System-control top: address decoder,
// device table and reset sequencer
// ****************************************

`timescale 1ns/10ps

`include "soc_params.svh"

module soc_ctrl_top (
	input  logic               clk48mhz_i,
	input  logic               rst_p,
	input  logic               cpu_rst_req_i,
	input  soc_pkg::pi1_req_t  m_req_i,
	output soc_pkg::pi1_rsp_t  m_rsp_o,
	output soc_pkg::ext_req_t  ext_req_o,
	input  soc_pkg::pi1_rsp_t  ext_rsp_i,
	output logic               sys_rst_o
);

	import soc_pkg::*;

	// Decoder to device table link
	pi1_req_t  tbl_req;
	pi1_rsp_t  tbl_rsp;

	// Reset-control levels from the device table
	logic      sw_rst0;
	logic      sw_rst1;

	pi1_addr_decoder i_decoder (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.m_req_i    (m_req_i),
		.m_rsp_o    (m_rsp_o),
		.tbl_req_o  (tbl_req),
		.tbl_rsp_i  (tbl_rsp),
		.ext_req_o  (ext_req_o),
		.ext_rsp_i  (ext_rsp_i)
	);

	// System reset clears the device table, which ends a warm reset request
	devtbl i_devtbl (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (sys_rst_o),
		.req_i      (tbl_req),
		.rsp_o      (tbl_rsp),
		.sw_rst0_o  (sw_rst0),
		.sw_rst1_o  (sw_rst1)
	);

	reset_sequencer i_rst_seq (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.cpu_rst_req_i (cpu_rst_req_i),
		.sw_rst0_i     (sw_rst0),
		.sw_rst1_i     (sw_rst1),
		.sys_rst_o     (sys_rst_o)
	);

endmodule

// File: test/tb_soc_ctrl.sv
// ****************************************
// Testbench for the system-control block:
// LFSR stimulus, external slave model,
// reference decode, checks and watchdog
// ****************************************

`timescale 1ns/10ps

`include "soc_params.svh"

module tb_soc_ctrl;

	import soc_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int DRV_DLY     = 10;
	localparam int RST_CYCLES  = 10;
	localparam int RST_HOLD    = (1 << `RST_CNTR_BITSZ) - 1;
	localparam int BUS_TIMEOUT = 8;
	// All tests together take about 1,000 cycles
	localparam int WD_CYCLES   = 20_000;

	localparam logic [31:0] MAP_WORDS [`SLOTCOUNT] = '{
		`MAPSZ_RAM, `MAPSZ_RAMCTRL, `MAPSZ_BOOTLDR, `MAPSZ_SDCARD,
		`MAPSZ_DEVTBL, `MAPSZ_INTCTRL, `MAPSZ_SERIAL, `MAPSZ_INVALID
	};
	localparam logic [31:0] DEV_IDS [`SLOTCOUNT] = '{
		`DEVID_RAM, `DEVID_RAMCTRL, `DEVID_BOOTLDR, `DEVID_SDCARD,
		`DEVID_DEVTBL, `DEVID_INTCTRL, `DEVID_SERIAL, `DEVID_INVALID
	};
	localparam logic [`SLOTCOUNT-1:0] USEINTR = `USEINTR_MASK;
	// Slots served through the external port
	localparam logic [2:0] EXT_SLOTS [6] = '{
		SLOT_RAM, SLOT_RAMCTRL, SLOT_BOOTLDR, SLOT_SDCARD, SLOT_INTCTRL, SLOT_SERIAL
	};

	typedef struct packed {
		slot_e        slot;
		logic [31:0]  ofs;
		logic [31:0]  rdata;
	} exp_t;

	logic         clk48mhz_i = 1'b0;
	logic         rst_p;
	logic         cpu_rst_req;
	pi1_req_t     m_req;
	pi1_rsp_t     m_rsp;
	ext_req_t     ext_req;
	pi1_rsp_t     ext_rsp;
	logic         sys_rst;
	logic [15:0]  stim_lfsr  = 16'd50;
	logic [15:0]  model_lfsr = 16'd50;
	int           wait_left  = 0;
	int           main_errs  = 0;
	int           mon_errs   = 0;
	int           n_tests    = 0;
	int           n_failed   = 0;

	soc_ctrl_top i_dut (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.cpu_rst_req_i (cpu_rst_req),
		.m_req_i       (m_req),
		.m_rsp_o       (m_rsp),
		.ext_req_o     (ext_req),
		.ext_rsp_i     (ext_rsp),
		.sys_rst_o     (sys_rst)
	);

	always #(CLK_PERIOD / 2) clk48mhz_i = ~clk48mhz_i;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v  = {v[30:0], st[0]};
			st = lfsr_next(st);
		end
	endtask

	function automatic logic [31:0] slot_base(input int k);
		logic [31:0] b;
		b = '0;
		for (int i = 0; i < k; i++) b = b + MAP_WORDS[i];
		return b;
	endfunction

	// Reset-control is only read after a system reset has cleared it
	function automatic logic [31:0] devtbl_word(input logic [31:0] ofs);
		logic [31:0] w;
		w = '0;
		if (ofs < 32'(2 * `SLOTCOUNT)) begin
			if (ofs[0]) begin
				w     = MAP_WORDS[ofs[3:1]];
				w[31] = USEINTR[ofs[3:1]];
			end else begin
				w = DEV_IDS[ofs[3:1]];
			end
		end else if (ofs == `DEVTBL_SOCID_OFS) begin
			w = `SOCID;
		end
		return w;
	endfunction

	// Expected slot, offset and read data of a master access
	function automatic exp_t ref_access(input logic [31:0] addr);
		exp_t e;
		e.slot  = SLOT_INVALID;
		e.ofs   = addr - slot_base(`SLOTCOUNT - 1);
		e.rdata = '0;
		if (addr < slot_base(`SLOTCOUNT)) begin
			for (int k = 0; k < `SLOTCOUNT; k++) begin
				if (addr >= slot_base(k)) begin
					e.slot = slot_e'(3'(k));
					e.ofs  = addr - slot_base(k);
				end
			end
		end
		if (e.slot == SLOT_DEVTBL) e.rdata = devtbl_word(e.ofs);
		else if (e.slot != SLOT_INVALID) e.rdata = e.ofs ^ (32'(e.slot) << 28);
		return e;
	endfunction

	task automatic compare_val(input string name, input logic [31:0] got,
		input logic [31:0] exp, inout int errs);
		if (got !== exp) begin
			errs++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic next_drive();
		@(posedge clk48mhz_i);
		#DRV_DLY;
	endtask

	// Present a request, hold it until rdy, then return to NOOP
	task automatic bus_access(input pi1_op_e op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output int lat);
		bit got;
		got  = 1'b0;
		lat  = 0;
		m_req.op   = op;
		m_req.addr = 30'(addr);
		m_req.data = wdata;
		m_req.sel  = sel;
		while (!got && lat < BUS_TIMEOUT) begin
			@(negedge clk48mhz_i);
			if (m_rsp.rdy === 1'b1) got = 1'b1;
			else lat++;
		end
		if (!got) begin
			main_errs++;
			$display("No rdy for %s at address %h within %0d cycles", op.name(), addr, lat);
		end
		next_drive();
		m_req.op = PI1_NOOP;
	endtask

	task automatic wait_rst_rise(input int max_cycles, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++) begin
			@(negedge clk48mhz_i);
			seen = (sys_rst === 1'b1);
		end
		if (!seen) begin
			main_errs++;
			$display("sys_rst_o did not rise within %0d cycles at %0t", max_cycles, $time);
		end
	endtask

	// Called at a falling edge that saw sys_rst_o high
	task automatic count_rst_high(output int n);
		n = 1;
		while (n < 4 * RST_HOLD) begin
			@(negedge clk48mhz_i);
			if (sys_rst !== 1'b1) break;
			n++;
		end
	endtask

	task automatic finish_test(input string name, input int errs0);
		n_tests++;
		if (main_errs + mon_errs == errs0) begin
			$display("test %-22s ok", name);
		end else begin
			n_failed++;
			$display("test %-22s FAILED, %0d errors", name, main_errs + mon_errs - errs0);
		end
	endtask

	// External slave model, latency of 0 to 3 cycles per transfer
	assign ext_rsp = {
		32'(ext_req.req.addr) ^ (32'(ext_req.slot) << 28),
		(ext_req.req.op != PI1_NOOP) && (wait_left == 0)
	};

	always begin
		bit busy;
		bit done;
		logic [31:0] r;
		@(posedge clk48mhz_i);
		busy = (ext_req.req.op != PI1_NOOP);
		done = busy && (wait_left == 0);
		#DRV_DLY;
		if (done) begin
			take_bits(model_lfsr, 2, r);
			wait_left = int'(r);
		end else if (busy) begin
			wait_left = wait_left - 1;
		end
	end

	// Checks routing and read data of every completed transfer
	always @(negedge clk48mhz_i) begin
		exp_t e;
		if (m_req.op != PI1_NOOP && m_rsp.rdy === 1'b1) begin
			e = ref_access(32'(m_req.addr));
			if (e.slot inside {SLOT_DEVTBL, SLOT_INVALID}) begin
				compare_val("ext_req_o.req.op", 32'(ext_req.req.op), 32'(PI1_NOOP), mon_errs);
			end else begin
				compare_val("ext_req_o.slot", 32'(ext_req.slot), 32'(e.slot), mon_errs);
				compare_val("ext_req_o.req.addr", 32'(ext_req.req.addr), e.ofs, mon_errs);
				compare_val("ext_req_o.req.op", 32'(ext_req.req.op), 32'(m_req.op), mon_errs);
				compare_val("ext_req_o.req.data", ext_req.req.data, m_req.data, mon_errs);
				compare_val("ext_req_o.req.sel", 32'(ext_req.req.sel), 32'(m_req.sel), mon_errs);
			end
			if (m_req.op inside {PI1_RDOP, PI1_RDWROP})
				compare_val("m_rsp_o.data", m_rsp.data, e.rdata, mon_errs);
		end
	end

	initial begin
		int lat;
		int n;
		int errs0;
		bit seen;
		logic [31:0] r;
		logic [31:0] ofs;
		logic [31:0] wd;
		logic [31:0] sel;
		logic [31:0] bad_addr [5];
		int k;
		rst_p       = 1'b1;
		cpu_rst_req = 1'b0;
		m_req       = '0;
		repeat (RST_CYCLES) @(posedge clk48mhz_i);
		#DRV_DLY;

		errs0 = main_errs + mon_errs;
		rst_p = 1'b0;
		wait_rst_rise(1, seen);
		if (seen) count_rst_high(n);
		if (seen) compare_val("sys_rst_o high cycles", n, RST_HOLD, main_errs);
		next_drive();
		finish_test("reset release", errs0);

		errs0 = main_errs + mon_errs;
		for (int i = 0; i <= `DEVTBL_RSTCTL_OFS + 1; i++) begin
			bus_access(PI1_RDOP, slot_base(SLOT_DEVTBL) + i, '0, 4'hf, lat);
			compare_val("devtbl rdy latency", lat, 1, main_errs);
		end
		finish_test("device table reads", errs0);

		errs0 = main_errs + mon_errs;
		for (int i = 0; i < 40; i++) begin
			take_bits(stim_lfsr, 3, r);
			k = int'(EXT_SLOTS[r % 6]);
			take_bits(stim_lfsr, 25, ofs);
			take_bits(stim_lfsr, 32, wd);
			take_bits(stim_lfsr, 4, sel);
			take_bits(stim_lfsr, 1, r);
			ofs = ofs & (MAP_WORDS[k] - 1);
			bus_access(r[0] ? PI1_WROP : PI1_RDOP, slot_base(k) + ofs, wd, sel[3:0], lat);
		end
		finish_test("external accesses", errs0);

		errs0 = main_errs + mon_errs;
		bad_addr[0] = slot_base(SLOT_INVALID);
		bad_addr[1] = slot_base(`SLOTCOUNT) - 1;
		bad_addr[2] = slot_base(`SLOTCOUNT);
		bad_addr[3] = slot_base(`SLOTCOUNT) + 32'h1234;
		bad_addr[4] = 32'h3fff_ffff;
		for (int i = 0; i < 5; i++) begin
			bus_access(PI1_RDOP, bad_addr[i], '0, 4'hf, lat);
			compare_val("invalid rdy latency", lat, 0, main_errs);
			bus_access(PI1_WROP, bad_addr[i], 32'hdead_beef, 4'hf, lat);
		end
		finish_test("invalid device", errs0);

		errs0 = main_errs + mon_errs;
		// Warm code is rst1 set, rst0 clear
		bus_access(PI1_WROP, slot_base(SLOT_DEVTBL) + `DEVTBL_RSTCTL_OFS, 32'h2, 4'h1, lat);
		wait_rst_rise(3, seen);
		if (seen) count_rst_high(n);
		if (seen) compare_val("sys_rst_o min high cycles", (n < RST_HOLD) ? n : RST_HOLD,
			RST_HOLD, main_errs);
		next_drive();
		bus_access(PI1_RDOP, slot_base(SLOT_DEVTBL) + `DEVTBL_RSTCTL_OFS, '0, 4'hf, lat);
		cpu_rst_req = 1'b1;
		next_drive();
		cpu_rst_req = 1'b0;
		wait_rst_rise(2, seen);
		if (seen) count_rst_high(n);
		if (seen) compare_val("sys_rst_o min high cycles", (n < RST_HOLD) ? n : RST_HOLD,
			RST_HOLD, main_errs);
		next_drive();
		bus_access(PI1_RDOP, slot_base(SLOT_DEVTBL) + `DEVTBL_RSTCTL_OFS, '0, 4'hf, lat);
		finish_test("warm and cpu reset", errs0);

		errs0 = main_errs + mon_errs;
		bus_access(PI1_WROP, slot_base(SLOT_DEVTBL) + `DEVTBL_RSTCTL_OFS, 32'h1, 4'h1, lat);
		wait_rst_rise(3, seen);
		n = 0;
		repeat (200) begin
			@(negedge clk48mhz_i);
			if (sys_rst !== 1'b1) n++;
		end
		compare_val("sys_rst_o low cycles in power-off", n, 0, main_errs);
		next_drive();
		rst_p = 1'b1;
		next_drive();
		next_drive();
		rst_p = 1'b0;
		wait_rst_rise(1, seen);
		if (seen) count_rst_high(n);
		if (seen) compare_val("sys_rst_o high cycles", n, RST_HOLD, main_errs);
		next_drive();
		finish_test("power-off latch", errs0);

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, main_errs + mon_errs);
		if (main_errs + mon_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Watchdog stopped the run after %0d cycles", WD_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
rtl/soc_pkg.sv
rtl/reset_sequencer.sv
rtl/pi1_addr_decoder.sv
rtl/devtbl.sv
rtl/soc_ctrl_top.sv
test/tb_soc_ctrl.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_soc_ctrl
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
